//--- Makefile
# Verilator build and run for the I/O block testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_io_top
FILELIST  := files.f
BUILD_DIR := obj_dir
LOG       := sim.log
SIM_ARGS  := +verilator+error+limit+1000

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; exit 1; \
	elif ! grep -q "Verification passed" $(LOG); then \
		echo "simulation ended without a verdict, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/io_monitor.sv
// I/O block monitor
// snoops bus cycles, models LED and rate registers, decodes the serial line

`timescale 1ns/100ps
`default_nettype none

module io_monitor (
    input  wire logic                         clk_cpu,
    input  wire logic                         rst_n,
    input  wire logic                         wb_we_i,
    input  wire io_map_pkg::io_addr_u         wb_adr_i,
    input  wire logic [31:0]                  wb_dat_i,
    input  wire logic [3:0]                   wb_sel_i,
    input  wire logic [31:0]                  rd_dat_i,
    input  wire logic                         ack_i,
    input  wire logic [io_map_pkg::led_w-1:0] led_i,
    input  wire logic                         tx_i,
    output      int                           err_count_o,
    output      logic                         pending_o
);

    string                           test_name = "none";
    int                              errors = 0;
    logic [7:0]                      exp_q [$];     // written bytes not yet seen on tx
    logic [io_map_pkg::led_w-1:0]    led_model;
    logic                            rate_model;
    logic [31:0]                     last_ms;
    int                              run_cycles;
    logic                            rx_active;
    int                              rx_div;
    int                              rx_ph;
    int                              rx_bit;
    logic [uart_pkg::frame_bits-1:0] rx_frame;

    assign err_count_o = errors;

    task automatic set_test(input string name);
        test_name = name;
    endtask

    task automatic report(input string what, input logic [31:0] exp, input logic [31:0] act);
        $display("MISMATCH %s %s: expected 'h%0h, actual 'h%0h", test_name, what, exp, act);
        errors++;
    endtask

    task automatic check_cycle();
        logic        in_win;
        logic [3:0]  word;
        logic [31:0] exp_rd;
        in_win = (wb_adr_i.rgn.region == io_map_pkg::io_region);
        word   = wb_adr_i.wrd.word;
        if (wb_we_i) begin
            if (in_win && wb_sel_i[0]) begin
                if (word == io_map_pkg::reg_led)
                    led_model = wb_dat_i[io_map_pkg::led_w-1:0];
                else if (word == io_map_pkg::reg_tx_data)
                    exp_q.push_back(wb_dat_i[7:0]);
                else if (word == io_map_pkg::reg_tx_stat)
                    rate_model = wb_dat_i[0];
            end
        end else if (in_win && word == io_map_pkg::reg_ms) begin
            exp_rd = 32'(run_cycles / uart_pkg::ms_limit);
            if (rd_dat_i + 32'd1 < exp_rd || rd_dat_i > exp_rd + 32'd1)
                report("ms count", exp_rd, rd_dat_i);   // one ms of slack
            if (rd_dat_i < last_ms)
                report("ms count went back", last_ms, rd_dat_i);
            last_ms = rd_dat_i;
        end else if (in_win && word == io_map_pkg::reg_tx_stat) begin
            if (rd_dat_i[31:2] != '0)
                report("status upper bits", 32'h0, rd_dat_i);
        end else begin
            exp_rd = '0;
            if (in_win && word == io_map_pkg::reg_led)
                exp_rd = 32'(led_model);
            if (rd_dat_i !== exp_rd)
                report("read data", exp_rd, rd_dat_i);
        end
    endtask

    task automatic check_frame();
        logic [7:0] exp_byte;
        if (rx_frame[0] != 1'b0 || rx_frame[uart_pkg::frame_bits-1] != 1'b1) begin
            $display("%s: bad start or stop bit in frame 'h%0h", test_name, rx_frame);
            errors++;
        end
        if (exp_q.size() == 0) begin
            $display("%s: frame 'h%0h arrived with no byte written", test_name, rx_frame[8:1]);
            errors++;
        end else begin
            exp_byte = exp_q.pop_front();
            if (rx_frame[8:1] != exp_byte)
                report("tx byte", 32'(exp_byte), 32'(rx_frame[8:1]));
        end
    endtask

    // bit period is fixed at the start bit and each bit is sampled mid-way
    task automatic watch_line();
        if (!rx_active) begin
            if (tx_i == 1'b0) begin
                rx_active = 1'b1;
                rx_div    = rate_model ? uart_pkg::div_slow : uart_pkg::div_fast;
                rx_ph     = 1;
                rx_bit    = 0;
                rx_frame  = '0;
            end
        end else begin
            if (rx_ph == rx_div / 2)
                rx_frame[rx_bit] = tx_i;
            if (rx_ph == rx_div - 1) begin
                rx_ph = 0;
                rx_bit++;
                if (rx_bit == uart_pkg::frame_bits) begin
                    rx_active = 1'b0;
                    check_frame();
                end
            end else begin
                rx_ph++;
            end
        end
    endtask

    // DUT outputs are stable at the falling edge
    always @(negedge clk_cpu) begin
        if (!rst_n) begin
            led_model  = '0;
            rate_model = 1'b0;
            last_ms    = '0;
            run_cycles = 0;
            rx_active  = 1'b0;
            exp_q.delete();
        end else begin
            run_cycles++;
            if (ack_i)
                check_cycle();
            if (led_i !== led_model) begin
                report("led_o", 32'(led_model), 32'(led_i));
                led_model = led_i;  // resync so each change reports once
            end
            watch_line();
        end
        pending_o = rx_active || (exp_q.size() != 0);
    end

endmodule

`default_nettype wire

//--- dv/io_top_chk.sv
// bus handshake and serial line checks
// bound into io_top

`timescale 1ns/100ps
`default_nettype none

module io_top_chk (
    input wire logic clk_cpu,
    input wire logic rst_n,
    input wire logic wb_cyc_i,
    input wire logic wb_stb_i,
    input wire logic wb_ack_i,
    input wire logic tx_busy_i,
    input wire logic tx_i
);

    int assert_fails = 0;   // failure count for the closing report

    ack_pulse: assert property (@(posedge clk_cpu) disable iff (!rst_n)
        wb_ack_i |=> !wb_ack_i)
        else begin
            $error("ack held high for two cycles");
            assert_fails++;
        end

    ack_in_cycle: assert property (@(posedge clk_cpu) disable iff (!rst_n)
        wb_ack_i |-> (wb_cyc_i && wb_stb_i))
        else begin
            $error("ack raised outside an active bus cycle");
            assert_fails++;
        end

    // idle serializer keeps the line at mark level
    line_idle: assert property (@(posedge clk_cpu) disable iff (!rst_n)
        !tx_busy_i |-> tx_i)
        else begin
            $error("transmit line low while serializer idle");
            assert_fails++;
        end

endmodule

bind io_top io_top_chk u_chk (
    .clk_cpu   (clk_cpu),
    .rst_n     (rst_n),
    .wb_cyc_i  (wb_cyc_i),
    .wb_stb_i  (wb_stb_i),
    .wb_ack_i  (wb_ack_o),
    .tx_busy_i (tx_busy),
    .tx_i      (tx_o)
);

`default_nettype wire

//--- dv/tb_io_top.sv
// testbench for the I/O block
// random Wishbone traffic on the LED, transmit, status and timer registers

`timescale 1ns/100ps
`default_nettype none

module tb_io_top;

    localparam int n_frames  = 8 + 24 + 4;     // bytes sent over all tests
    localparam int wd_cycles = n_frames * uart_pkg::frame_bits * uart_pkg::div_slow
                               + 100_000;

    logic                         clk_cpu;
    logic                         rst_n;
    logic                         wb_cyc;
    logic                         wb_stb;
    logic                         wb_we;
    io_map_pkg::io_addr_u         wb_adr;
    logic [31:0]                  wb_dat_w;
    logic [31:0]                  wb_dat_r;
    logic [3:0]                   wb_sel;
    logic                         wb_ack;
    logic [io_map_pkg::led_w-1:0] led;
    logic                         tx;
    logic [31:0]                  seed = 32'ha482_deab;
    string                        cur_test = "reset";
    int                           tb_errors = 0;
    int                           mon_errors;
    logic                         mon_pending;

    io_top DUT (
        .clk_cpu  (clk_cpu),
        .rst_n    (rst_n),
        .wb_cyc_i (wb_cyc),
        .wb_stb_i (wb_stb),
        .wb_we_i  (wb_we),
        .wb_adr_i (wb_adr),
        .wb_dat_i (wb_dat_w),
        .wb_sel_i (wb_sel),
        .wb_dat_o (wb_dat_r),
        .wb_ack_o (wb_ack),
        .led_o    (led),
        .tx_o     (tx)
    );

    io_monitor u_monitor (
        .clk_cpu     (clk_cpu),
        .rst_n       (rst_n),
        .wb_we_i     (wb_we),
        .wb_adr_i    (wb_adr),
        .wb_dat_i    (wb_dat_w),
        .wb_sel_i    (wb_sel),
        .rd_dat_i    (wb_dat_r),
        .ack_i       (wb_ack),
        .led_i       (led),
        .tx_i        (tx),
        .err_count_o (mon_errors),
        .pending_o   (mon_pending)
    );

    initial begin
        clk_cpu = 1'b0;
        forever #5 clk_cpu = ~clk_cpu;
    end

    // limit assumes every frame goes out at the slow rate
    initial begin : watchdog
        repeat (wd_cycles) @(posedge clk_cpu);
        $display("timeout: run still going after %0d cycles in test %s", wd_cycles, cur_test);
        $display("Verification failed");
        $finish;
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic io_map_pkg::io_addr_u make_addr(input logic [3:0] region,
                                                       input logic [3:0] word);
        io_map_pkg::io_addr_u a;
        a            = '0;
        a.wrd.word   = word;
        a.rgn.region = region;  // region view only touches the top nibble
        return a;
    endfunction

    task automatic start_test(input string name);
        cur_test = name;
        u_monitor.set_test(name);
    endtask

    task automatic check_equal(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("MISMATCH %s %s: expected 'h%0h, actual 'h%0h", cur_test, what, exp, act);
            tb_errors++;
        end
    endtask

    task automatic note_failure(input string what);
        $display("%s: %s", cur_test, what);
        tb_errors++;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk_cpu);
        #1;
    endtask

    // one classic cycle with inputs held until ack is seen
    task automatic bus_cycle(input logic we, input io_map_pkg::io_addr_u adr,
                             input logic [31:0] data, output logic [31:0] rdata,
                             output int waits);
        waits    = 0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = data;
        wb_sel   = 4'hF;
        @(negedge clk_cpu);
        while (!wb_ack) begin
            waits++;
            @(negedge clk_cpu);
        end
        rdata = wb_dat_r;
        @(posedge clk_cpu);
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic write_word(input io_map_pkg::io_addr_u adr, input logic [31:0] data);
        logic [31:0] unused;
        int          w;
        bus_cycle(1'b1, adr, data, unused, w);
    endtask

    task automatic read_word(input io_map_pkg::io_addr_u adr, output logic [31:0] data);
        int w;
        bus_cycle(1'b0, adr, 32'h0, data, w);
    endtask

    // poll status bit 1 until queue and serializer are both empty
    task automatic wait_drained();
        logic [31:0] st;
        read_word(make_addr(io_map_pkg::io_region, io_map_pkg::reg_tx_stat), st);
        while (!st[1]) begin
            wait_cycles(50);
            read_word(make_addr(io_map_pkg::io_region, io_map_pkg::reg_tx_stat), st);
        end
        if (mon_pending)
            note_failure("bytes still expected after the line drained");
    endtask

    initial begin : stimulus
        logic [31:0]          rd;
        logic [31:0]          rnd;
        logic [3:0]           rgn;
        logic [3:0]           word;
        int                   w;
        int                   delayed;
        logic                 saw_full;
        io_map_pkg::io_addr_u tx_adr;
        io_map_pkg::io_addr_u stat_adr;
        tx_adr   = make_addr(io_map_pkg::io_region, io_map_pkg::reg_tx_data);
        stat_adr = make_addr(io_map_pkg::io_region, io_map_pkg::reg_tx_stat);
        rst_n    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        wb_sel   = '0;
        repeat (10) @(posedge clk_cpu);
        #1 rst_n = 1'b1;
        wait_cycles(2);

        start_test("reset");
        check_equal("led_o", 32'h0, 32'(led));
        check_equal("tx_o", 32'h1, 32'(tx));

        start_test("led");
        repeat (12) begin
            rnd = next_rand();
            write_word(make_addr(io_map_pkg::io_region, io_map_pkg::reg_led), rnd);
            read_word(make_addr(io_map_pkg::io_region, io_map_pkg::reg_led), rd);
            check_equal("led readback", {24'h0, rnd[7:0]}, rd);
        end

        start_test("tx_fast");
        repeat (8) write_word(tx_adr, next_rand());
        wait_drained();

        start_test("backpressure");
        delayed  = 0;
        saw_full = 1'b0;
        repeat (24) begin
            bus_cycle(1'b1, tx_adr, next_rand(), rd, w);
            if (w > 2)
                delayed++;  // ack held while the queue was full
            read_word(stat_adr, rd);
            if (!rd[0])
                saw_full = 1'b1;
        end
        if (delayed == 0)
            note_failure("no transmit write was held off by a full queue");
        if (!saw_full)
            note_failure("status never showed a full queue during the burst");
        wait_drained();

        start_test("rate_slow");
        write_word(stat_adr, 32'h1);
        repeat (4) write_word(tx_adr, next_rand());
        wait_drained();
        write_word(stat_adr, 32'h0);

        start_test("ms_count");
        repeat (6) begin
            rnd = next_rand();
            wait_cycles(int'(rnd[13:0]));
            read_word(make_addr(io_map_pkg::io_region, io_map_pkg::reg_ms), rd);
        end

        start_test("decode");
        read_word(tx_adr, rd);
        check_equal("tx data read", 32'h0, rd);
        repeat (16) begin
            rnd = next_rand();
            rgn = rnd[31:28];
            if (rgn == io_map_pkg::io_region)
                rgn = rgn ^ 4'h1;
            read_word(make_addr(rgn, rnd[3:0]), rd);
            check_equal("outside read", 32'h0, rd);
            write_word(make_addr(rgn, rnd[3:0]), next_rand());
            word = 4'd4 + rnd[7:4] % 4'd12;     // words 4 to 15 are unmapped
            read_word(make_addr(io_map_pkg::io_region, word), rd);
            check_equal("unmapped read", 32'h0, rd);
            write_word(make_addr(io_map_pkg::io_region, word), next_rand());
        end
        wait_cycles(3 * uart_pkg::frame_bits * uart_pkg::div_fast);
        if (tx !== 1'b1 || mon_pending)
            note_failure("serial line active after writes outside the map");

        wait_cycles(2);
        $display("errors: monitor %0d, testbench %0d, assertions %0d",
                 mon_errors, tb_errors, DUT.u_chk.assert_fails);
        if (mon_errors + tb_errors + DUT.u_chk.assert_fails == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
src/io_map_pkg.sv
src/uart_pkg.sv
src/ms_timer.sv
src/io_bus_regs.sv
src/tx_fifo.sv
src/uart_tx.sv
src/io_top.sv
dv/io_top_chk.sv
dv/io_monitor.sv
dv/tb_io_top.sv

//--- src/io_bus_regs.sv
// Wishbone classic slave for the I/O window
// holds LED and rate registers, pushes transmit bytes, answers status reads

`timescale 1ns/100ps
`default_nettype none

module io_bus_regs (
    input  wire logic                           clk_cpu,
    input  wire logic                           rst_n,
    input  wire logic                           wb_cyc_i,
    input  wire logic                           wb_stb_i,
    input  wire logic                           wb_we_i,
    input  wire io_map_pkg::io_addr_u           wb_adr_i,
    input  wire logic [io_map_pkg::dat_w-1:0]   wb_dat_i,
    input  wire logic [3:0]                     wb_sel_i,
    output      logic [io_map_pkg::dat_w-1:0]   wb_dat_o,
    output      logic                           wb_ack_o,
    input  wire logic [31:0]                    ms_count_i,
    input  wire logic                           fifo_full_i,
    input  wire logic                           fifo_empty_i,
    output      logic                           push_o,
    output      logic [7:0]                     push_data_o,
    input  wire logic                           tx_busy_i,
    output      logic                           rate_slow_o,
    output      logic [io_map_pkg::led_w-1:0]   led_o
);

    logic                         pend;     // cycle seen and not yet acked
    logic                         in_win;
    logic                         is_tx_wr;
    logic                         go;       // ack edge for the pending cycle
    logic [io_map_pkg::dat_w-1:0] rd_data;

    assign in_win   = (wb_adr_i.rgn.region == io_map_pkg::io_region);
    assign is_tx_wr = wb_we_i && in_win && wb_sel_i[0]
                      && (wb_adr_i.wrd.word == io_map_pkg::reg_tx_data);

    // a transmit write waits here while the queue is full
    assign go = pend && !(is_tx_wr && fifo_full_i);

    assign push_o      = go && is_tx_wr;
    assign push_data_o = wb_dat_i[7:0];     // byte lane 0

    always_comb begin
        rd_data = '0;
        if (in_win) begin
            case (wb_adr_i.wrd.word)
                io_map_pkg::reg_ms:      rd_data = ms_count_i;
                io_map_pkg::reg_led:     rd_data = io_map_pkg::dat_w'(led_o);
                io_map_pkg::reg_tx_stat: begin
                    rd_data[0] = !fifo_full_i;
                    rd_data[1] = fifo_empty_i && !tx_busy_i;   // line drained
                end
                default:                 rd_data = '0;
            endcase
        end
    end

    // registered handshake with one wait cycle before ack
    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            pend     <= 1'b0;
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= go;
            if (go)
                pend <= 1'b0;
            else if (wb_cyc_i && wb_stb_i && !wb_ack_o)
                pend <= 1'b1;
        end
    end

    always_ff @(posedge clk_cpu) begin
        if (go)
            wb_dat_o <= wb_we_i ? '0 : rd_data;
    end

    // register writes land with the ack
    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            led_o       <= '0;
            rate_slow_o <= 1'b0;
        end else if (go && wb_we_i && in_win && wb_sel_i[0]) begin
            if (wb_adr_i.wrd.word == io_map_pkg::reg_led)
                led_o <= wb_dat_i[io_map_pkg::led_w-1:0];
            if (wb_adr_i.wrd.word == io_map_pkg::reg_tx_stat)
                rate_slow_o <= wb_dat_i[0];
        end
    end

endmodule

`default_nettype wire

//--- src/io_map_pkg.sv
// I/O window address map
// register word indices, bus widths and the two views of a bus address

`default_nettype none

package io_map_pkg;

    localparam int adr_w = 32;
    localparam int dat_w = 32;

    localparam logic [3:0] io_region = 4'hE;    // top nibble of the I/O window

    // word indices inside the window
    localparam logic [3:0] reg_ms      = 4'd0;  // millisecond count, read only
    localparam logic [3:0] reg_led     = 4'd1;
    localparam logic [3:0] reg_tx_data = 4'd2;  // write pushes a byte
    localparam logic [3:0] reg_tx_stat = 4'd3;  // status read, rate control write

    localparam int led_w = 8;

    // one address word, decoded either by region or by word and lane
    typedef union packed {
        struct packed {
            logic [3:0]       region;
            logic [adr_w-5:0] offset;
        } rgn;
        struct packed {
            logic [adr_w-7:0] upper;
            logic [3:0]       word;
            logic [1:0]       lane;
        } wrd;
    } io_addr_u;

endpackage

`default_nettype wire

//--- src/io_top.sv
// memory-mapped I/O block
// Wishbone slave with ms timer, LED register and queued UART transmit

`timescale 1ns/100ps
`default_nettype none

module io_top (
    input  wire logic                           clk_cpu,
    input  wire logic                           rst_n,
    input  wire logic                           wb_cyc_i,
    input  wire logic                           wb_stb_i,
    input  wire logic                           wb_we_i,
    input  wire io_map_pkg::io_addr_u           wb_adr_i,
    input  wire logic [io_map_pkg::dat_w-1:0]   wb_dat_i,
    input  wire logic [3:0]                     wb_sel_i,
    output      logic [io_map_pkg::dat_w-1:0]   wb_dat_o,
    output      logic                           wb_ack_o,
    output      logic [io_map_pkg::led_w-1:0]   led_o,
    output      logic                           tx_o
);

    logic [31:0] ms_count;
    logic        fifo_full;
    logic        fifo_empty;
    logic        push;
    logic [7:0]  push_data;
    logic        pop;
    logic [7:0]  head;
    logic        tx_busy;
    logic        rate_slow;

    ms_timer u_ms_timer (
        .clk_cpu    (clk_cpu),
        .rst_n      (rst_n),
        .ms_count_o (ms_count)
    );

    io_bus_regs u_regs (
        .clk_cpu      (clk_cpu),
        .rst_n        (rst_n),
        .wb_cyc_i     (wb_cyc_i),
        .wb_stb_i     (wb_stb_i),
        .wb_we_i      (wb_we_i),
        .wb_adr_i     (wb_adr_i),
        .wb_dat_i     (wb_dat_i),
        .wb_sel_i     (wb_sel_i),
        .wb_dat_o     (wb_dat_o),
        .wb_ack_o     (wb_ack_o),
        .ms_count_i   (ms_count),
        .fifo_full_i  (fifo_full),
        .fifo_empty_i (fifo_empty),
        .push_o       (push),
        .push_data_o  (push_data),
        .tx_busy_i    (tx_busy),
        .rate_slow_o  (rate_slow),
        .led_o        (led_o)
    );

    tx_fifo u_fifo (
        .clk_cpu     (clk_cpu),
        .rst_n       (rst_n),
        .push_i      (push),
        .push_data_i (push_data),
        .pop_i       (pop),
        .head_o      (head),
        .full_o      (fifo_full),
        .empty_o     (fifo_empty)
    );

    uart_tx u_uart (
        .clk_cpu     (clk_cpu),
        .rst_n       (rst_n),
        .empty_i     (fifo_empty),
        .head_i      (head),
        .pop_o       (pop),
        .rate_slow_i (rate_slow),
        .busy_o      (tx_busy),
        .tx_o        (tx_o)
    );

endmodule

`default_nettype wire

//--- src/ms_timer.sv
// millisecond timer
// free-running count of whole milliseconds since reset release

`timescale 1ns/100ps
`default_nettype none

module ms_timer (
    input  wire logic        clk_cpu,
    input  wire logic        rst_n,
    output      logic [31:0] ms_count_o
);

    localparam int pre_w = $clog2(uart_pkg::ms_limit);

    logic [pre_w-1:0] pre_cnt;      // cycles within current millisecond
    logic             pre_wrap;

    assign pre_wrap = (pre_cnt == pre_w'(uart_pkg::ms_limit - 1));

    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            pre_cnt    <= '0;
            ms_count_o <= '0;
        end else if (pre_wrap) begin
            pre_cnt    <= '0;
            ms_count_o <= ms_count_o + 32'd1;
        end else begin
            pre_cnt <= pre_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- src/tx_fifo.sv
// transmit byte queue
// circular buffer between the register block and the serializer

`timescale 1ns/100ps
`default_nettype none

module tx_fifo (
    input  wire logic       clk_cpu,
    input  wire logic       rst_n,
    input  wire logic       push_i,
    input  wire logic [7:0] push_data_i,
    input  wire logic       pop_i,
    output      logic [7:0] head_o,
    output      logic       full_o,
    output      logic       empty_o
);

    localparam int ptr_w = $clog2(uart_pkg::fifo_depth);

    logic [7:0]                      mem [uart_pkg::fifo_depth];
    logic [ptr_w-1:0]                wr_ptr;
    logic [ptr_w-1:0]                rd_ptr;
    logic [uart_pkg::fifo_cnt_w-1:0] count;

    assign head_o  = mem[rd_ptr];
    assign empty_o = (count == '0);
    assign full_o  = (count == uart_pkg::fifo_cnt_w'(uart_pkg::fifo_depth));

    always_ff @(posedge clk_cpu) begin
        if (push_i)
            mem[wr_ptr] <= push_data_i;
    end

    // power-of-two depth lets the pointers wrap freely
    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop_i)
                rd_ptr <= rd_ptr + 1'b1;
            if (push_i && !pop_i)
                count <= count + 1'b1;
            else if (pop_i && !push_i)
                count <= count - 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- src/uart_pkg.sv
// serial transmit constants
// clock rate, bit-rate divisors, frame shape and queue size

`default_nettype none

package uart_pkg;

    localparam int clk_hz    = 25_000_000;
    localparam int ms_limit  = clk_hz / 1000;   // cycles per millisecond

    localparam int baud_fast = 115_200;
    localparam int baud_slow = 19_200;
    localparam int div_fast  = clk_hz / baud_fast;  // 217
    localparam int div_slow  = clk_hz / baud_slow;  // 1302
    localparam int div_w     = 11;

    // start + 8 data + stop
    localparam int frame_bits = 10;

    localparam int fifo_depth = 16;
    localparam int fifo_cnt_w = 5;              // holds 0..fifo_depth

endpackage

`default_nettype wire

//--- src/uart_tx.sv
// UART transmitter
// pops queued bytes and sends them as 8N1 frames, LSB first

`timescale 1ns/100ps
`default_nettype none

module uart_tx (
    input  wire logic       clk_cpu,
    input  wire logic       rst_n,
    input  wire logic       empty_i,
    input  wire logic [7:0] head_i,
    output      logic       pop_o,
    input  wire logic       rate_slow_i,
    output      logic       busy_o,
    output      logic       tx_o
);

    localparam int bit_w = $clog2(uart_pkg::frame_bits);

    logic                           busy;
    logic [uart_pkg::frame_bits-2:0] shreg;     // data bits then stop bit
    logic [bit_w-1:0]               bit_cnt;
    logic [uart_pkg::div_w-1:0]     div_cnt;
    logic [uart_pkg::div_w-1:0]     div_lat;   // bit period for this frame
    logic                           bit_end;

    assign pop_o   = !busy && !empty_i;
    assign busy_o  = busy;
    assign bit_end = (div_cnt == div_lat - 1'b1);

    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            tx_o    <= 1'b1;    // line idles high
            bit_cnt <= '0;
            div_cnt <= '0;
        end else if (!busy) begin
            if (!empty_i) begin
                busy    <= 1'b1;
                tx_o    <= 1'b0;    // start bit
                bit_cnt <= '0;
                div_cnt <= '0;
            end
        end else if (bit_end) begin
            div_cnt <= '0;
            if (bit_cnt == bit_w'(uart_pkg::frame_bits - 1)) begin
                busy <= 1'b0;   // end of stop bit
                tx_o <= 1'b1;
            end else begin
                tx_o    <= shreg[0];
                bit_cnt <= bit_cnt + 1'b1;
            end
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // frame payload and divisor, loaded at pop
    always_ff @(posedge clk_cpu) begin
        if (pop_o) begin
            shreg   <= {1'b1, head_i};
            div_lat <= rate_slow_i ? uart_pkg::div_w'(uart_pkg::div_slow)
                                   : uart_pkg::div_w'(uart_pkg::div_fast);
        end else if (busy && bit_end) begin
            shreg <= shreg >> 1;
        end
    end

endmodule

`default_nettype wire
